// ==== vlog.f ====
+incdir+common
common/dma_pkg.sv
design/dma_arbiter.sv
design/dma_mem.sv
design/dma_regs.sv
dma_engine/dma_engine.sv
design/dma_top.sv
tb/tb_dma_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DMA testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_dma_top -Mdir obj_dir -o sim_tb_dma_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb_dma_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "All tests passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tb/tb_dma_top.sv ====
// DMA subsystem testbench running table-driven copy scenarios over AXI4-Lite
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module tb_dma_top
	import dma_pkg::*;
();

	localparam int NT = 4;
	localparam logic [1:0] AXI_OKAY = 2'b00;

	logic               clk = 1'b0;
	logic               rst;
	logic [`ADDR_W-1:0] awaddr;
	logic               awvalid;
	logic               awready;
	data_t              wdata;
	logic               wvalid;
	logic               wready;
	logic [1:0]         bresp;
	logic               bvalid;
	logic               bready;
	logic [`ADDR_W-1:0] araddr;
	logic               arvalid;
	logic               arready;
	data_t              rdata;
	logic [1:0]         rresp;
	logic               rvalid;
	logic               rready;

	// scenario table with one row per test
	string      t_name [NT];
	word_addr_t t_src [NT][`NUM_CH];
	word_addr_t t_dst [NT][`NUM_CH];
	word_addr_t t_len [NT][`NUM_CH];
	ch_mask_t   t_en [NT];
	ch_mask_t   t_level [NT];
	ch_idx_t    t_first [NT]; // expected to finish first
	ch_mask_t   t_later [NT]; // still running when t_first is done

	data_t       exp_mem [`MEM_DEPTH]; // expected scratch contents
	logic [31:0] lfsr;
	string       cur;
	int          errors;
	int          cycles;
	int          cycle_limit;

	always #10 clk = ~clk;

	dma_top dma_top_inst (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("simulation timed out before all tests finished");
			$display("errors: %0d", errors);
			$display("Some tests failed");
			$finish;
		end
	end

	// fibonacci taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic data_t random_bits(input int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[`DATA_W-2:0], lfsr_bit()};
		return v;
	endfunction

	// destination background that differs per word
	function automatic data_t fill_word(input word_addr_t a);
		return 32'hc0de_0000 | data_t'(a);
	endfunction

	function automatic logic [`ADDR_W-1:0] mem_addr(input word_addr_t a);
		return `MEM_BASE + {2'b00, a, 2'b00};
	endfunction

	function automatic logic [`ADDR_W-1:0] reg_addr(input int ch, input logic [3:0] off);
		return `ADDR_W'(ch * `CH_STRIDE) | {8'h00, off};
	endfunction

	task automatic check_data(input string what, input data_t exp, input data_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, got %h", what, exp, act);
		end
	endtask

	task automatic check_mask(input string what, input ch_mask_t exp, input ch_mask_t act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %b, got %b", what, exp, act);
		end
	endtask

	task automatic check_resp(input string what, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %b, got %b", what, exp, act);
		end
	endtask

	task automatic axi_write(input logic [`ADDR_W-1:0] addr, input data_t data);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do
			@(posedge clk);
		while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do
			@(posedge clk);
		while (!bvalid); // bready stays high
		check_resp({cur, " bresp"}, AXI_OKAY, bresp);
	endtask

	task automatic axi_read(input logic [`ADDR_W-1:0] addr, output data_t data);
		araddr  <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		check_resp({cur, " rresp"}, AXI_OKAY, rresp);
	endtask

	task automatic set_ch(input int t, input int c, input int src, input int dst, input int len);
		t_src[t][c] = word_addr_t'(src);
		t_dst[t][c] = word_addr_t'(dst);
		t_len[t][c] = word_addr_t'(len);
		t_en[t][c]  = 1'b1;
	endtask

	task automatic build_table();
		for (int t = 0; t < NT; t++) begin
			t_en[t]    = '0;
			t_level[t] = '0;
			t_first[t] = '0;
			t_later[t] = '0;
		end
		t_name[0] = "single_channel";
		set_ch(0, 1, 'h00, 'h80, 8);
		t_first[0] = 3'd1;
		t_name[1] = "priority_level";
		set_ch(1, 2, 'h10, 'h90, 40);
		set_ch(1, 6, 'h40, 'hc0, 4);
		t_level[1] = 8'b0100_0000;
		t_first[1] = 3'd6;
		t_later[1] = 8'b0000_0100;
		t_name[2] = "round_robin";
		set_ch(2, 0, 'h00, 'h80, 32);
		set_ch(2, 5, 'h30, 'hb0, 1);
		t_first[2] = 3'd5;
		t_later[2] = 8'b0000_0001;
		// 16-word slot per channel and channel 3 left empty
		t_name[3] = "eight_channel";
		for (int c = 0; c < `NUM_CH; c++)
			set_ch(3, c, c * 16, 128 + c * 16, int'(random_bits(4)));
		t_len[3][3] = '0;
		t_level[3]  = ch_mask_t'(random_bits(`NUM_CH));
	endtask

	task automatic set_limit();
		int len_sum;
		cycle_limit = 4;
		for (int t = 0; t < NT; t++) begin
			len_sum = 0;
			for (int c = 0; c < `NUM_CH; c++)
				if (t_en[t][c])
					len_sum += int'(t_len[t][c]);
			// copy time plus roughly six cycles per AXI access
			cycle_limit += 4 * (3 * len_sum + 6 * (4 * len_sum + 6 * `NUM_CH + 8));
		end
	endtask

	task automatic run_test(input int t);
		data_t      st;
		data_t      rd;
		word_addr_t a;
		cur = t_name[t];
		for (int c = 0; c < `NUM_CH; c++) begin
			if (t_en[t][c]) begin
				for (int k = 0; k < int'(t_len[t][c]); k++) begin
					a = t_src[t][c] + word_addr_t'(k);
					exp_mem[a] = random_bits(`DATA_W);
					axi_write(mem_addr(a), exp_mem[a]);
				end
				for (int k = 0; k < int'(t_len[t][c]) || k == 0; k++) begin
					a = t_dst[t][c] + word_addr_t'(k);
					axi_write(mem_addr(a), fill_word(a));
				end
				axi_write(reg_addr(c, `REG_SRC), data_t'(t_src[t][c]));
				axi_write(reg_addr(c, `REG_DST), data_t'(t_dst[t][c]));
				axi_write(reg_addr(c, `REG_LEN), data_t'(t_len[t][c]));
			end
		end
		for (int c = 0; c < `NUM_CH; c++)
			if (t_en[t][c])
				axi_write(reg_addr(c, `REG_CTRL), data_t'({t_level[t][c], 1'b1}));

		if (t_later[t] != '0) begin
			do
				axi_read(`REG_STATUS, st);
			while (!st[t_first[t]]);
			check_mask({cur, " early done"}, '0, st[`NUM_CH-1:0] & t_later[t]);
			check_mask({cur, " early busy"}, t_later[t], st[2*`NUM_CH-1:`NUM_CH] & t_later[t]);
			for (int c = 0; c < `NUM_CH; c++) begin
				if (t_later[t][c]) begin
					a = t_dst[t][c] + t_len[t][c] - word_addr_t'(1); // last word not copied yet
					axi_read(mem_addr(a), rd);
					check_data({cur, " unfinished dst"}, fill_word(a), rd);
				end
			end
		end

		do
			axi_read(`REG_STATUS, st);
		while ((st[`NUM_CH-1:0] & t_en[t]) != t_en[t]);
		check_mask({cur, " done"}, t_en[t], st[`NUM_CH-1:0]);
		check_mask({cur, " busy"}, '0, st[2*`NUM_CH-1:`NUM_CH]);

		for (int c = 0; c < `NUM_CH; c++) begin
			if (t_en[t][c] && t_len[t][c] == '0) begin
				a = t_dst[t][c];
				axi_read(mem_addr(a), rd);
				check_data($sformatf("%s ch%0d untouched dst", cur, c), fill_word(a), rd);
			end
			for (int k = 0; t_en[t][c] && k < int'(t_len[t][c]); k++) begin
				a = t_src[t][c] + word_addr_t'(k);
				axi_read(mem_addr(a), rd);
				check_data($sformatf("%s ch%0d src %0d", cur, c, k), exp_mem[a], rd);
				axi_read(mem_addr(t_dst[t][c] + word_addr_t'(k)), rd);
				check_data($sformatf("%s ch%0d dst %0d", cur, c, k), exp_mem[a], rd);
			end
		end

		// write one to clear
		axi_write(`REG_STATUS, data_t'(t_en[t]));
		axi_read(`REG_STATUS, st);
		check_mask({cur, " done after clear"}, '0, st[`NUM_CH-1:0]);
	endtask

	initial begin
		lfsr    = 32'h63400c17;
		cur     = "reset";
		rst     <= 1'b1;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b1;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b1;
		build_table();
		set_limit();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		for (int t = 0; t < NT; t++)
			run_test(t);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/dma_top.sv ====
// DMA subsystem top joining register block, copy engine, arbiter and scratch memory
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dma_top
	import dma_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [`ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  data_t             wdata,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [`ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output data_t             rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready
);

	ch_mask_t   start;
	ch_mask_t   ch_level;
	ch_mask_t   done_set;
	ch_mask_t   busy;
	ch_mask_t   request;
	ch_mask_t   level;
	ch_idx_t    current_channel;
	ch_idx_t    granted_channel;
	word_addr_t ch_src [`NUM_CH];
	word_addr_t ch_dst [`NUM_CH];
	word_addr_t ch_len [`NUM_CH];
	word_addr_t a_addr;
	word_addr_t b_addr;
	logic       a_we;
	logic       b_we;
	data_t      a_wdata;
	data_t      a_rdata;
	data_t      b_wdata;
	data_t      b_rdata;

	dma_regs dma_regs_inst (
		.clk      (clk),
		.rst      (rst),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.start    (start),
		.ch_src   (ch_src),
		.ch_dst   (ch_dst),
		.ch_len   (ch_len),
		.ch_level (ch_level),
		.done_set (done_set),
		.busy     (busy),
		.a_addr   (a_addr),
		.a_we     (a_we),
		.a_wdata  (a_wdata),
		.a_rdata  (a_rdata)
	);

	dma_engine dma_engine_inst (
		.clk             (clk),
		.rst             (rst),
		.start           (start),
		.ch_src          (ch_src),
		.ch_dst          (ch_dst),
		.ch_len          (ch_len),
		.ch_level        (ch_level),
		.busy            (busy),
		.done_set        (done_set),
		.request         (request),
		.level           (level),
		.current_channel (current_channel),
		.granted_channel (granted_channel),
		.b_addr          (b_addr),
		.b_we            (b_we),
		.b_wdata         (b_wdata),
		.b_rdata         (b_rdata)
	);

	dma_arbiter dma_arbiter_inst (
		.request         (request),
		.level           (level),
		.current_channel (current_channel),
		.granted_channel (granted_channel)
	);

	dma_mem dma_mem_inst (
		.clk     (clk),
		.a_addr  (a_addr),
		.a_we    (a_we),
		.a_wdata (a_wdata),
		.a_rdata (a_rdata),
		.b_addr  (b_addr),
		.b_we    (b_we),
		.b_wdata (b_wdata),
		.b_rdata (b_rdata)
	);

endmodule

`default_nettype wire

// ==== dma_engine/dma_engine.sv ====
// DMA copy engine moving one word per grant with per-channel progress counters
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dma_engine
	import dma_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  ch_mask_t   start,
	input  word_addr_t ch_src [`NUM_CH],
	input  word_addr_t ch_dst [`NUM_CH],
	input  word_addr_t ch_len [`NUM_CH],
	input  ch_mask_t   ch_level,
	output ch_mask_t   busy,
	output ch_mask_t   done_set,
	output ch_mask_t   request,
	output ch_mask_t   level,
	output ch_idx_t    current_channel,
	input  ch_idx_t    granted_channel,
	output word_addr_t b_addr,
	output logic       b_we,
	output data_t      b_wdata,
	input  data_t      b_rdata
);

	typedef enum logic [1:0] {
		S_GRANT,
		S_WAIT,
		S_WRITE
	} state_t;

	state_t     state;
	ch_idx_t    sel;
	ch_idx_t    last_q;
	ch_mask_t   busy_q;
	ch_mask_t   lvl_q;
	ch_mask_t   zero_done_q;
	ch_mask_t   remain_nz;
	logic       last_word;
	data_t      data_q;
	word_addr_t src_ptr [`NUM_CH];
	word_addr_t dst_ptr [`NUM_CH];
	word_addr_t remain [`NUM_CH];

	always_comb begin
		for (int i = 0; i < `NUM_CH; i++)
			remain_nz[i] = remain[i] != '0;
	end

	assign busy            = busy_q;
	assign request         = busy_q & remain_nz;
	assign level           = lvl_q;
	assign current_channel = last_q;

	assign last_word = (state == S_WRITE) && (remain[sel] == word_addr_t'(1));
	assign done_set  = zero_done_q | (last_word ? (ch_mask_t'(1) << sel) : '0);

	// source read on grant, destination write two cycles on
	assign b_addr  = (state == S_WRITE) ? dst_ptr[sel] : src_ptr[granted_channel];
	assign b_we    = state == S_WRITE;
	assign b_wdata = data_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= S_GRANT;
			sel         <= '0;
			last_q      <= '0;
			busy_q      <= '0;
			lvl_q       <= '0;
			zero_done_q <= '0;
		end else begin
			zero_done_q <= '0;
			for (int i = 0; i < `NUM_CH; i++) begin
				if (start[i] && !busy_q[i]) begin
					lvl_q[i] <= ch_level[i];
					if (ch_len[i] == '0)
						zero_done_q[i] <= 1'b1; // nothing to move
					else
						busy_q[i] <= 1'b1;
				end
			end

			case (state)
				S_GRANT: begin
					if (|request) begin
						sel   <= granted_channel;
						state <= S_WAIT;
					end
				end
				S_WAIT: state <= S_WRITE;
				S_WRITE: begin
					last_q <= sel;
					state  <= S_GRANT;
					if (last_word)
						busy_q[sel] <= 1'b0;
				end
				default: state <= S_GRANT;
			endcase
		end
	end

	// progress counters and read data
	always_ff @(posedge clk) begin
		for (int i = 0; i < `NUM_CH; i++) begin
			if (start[i] && !busy_q[i]) begin
				src_ptr[i] <= ch_src[i];
				dst_ptr[i] <= ch_dst[i];
				remain[i]  <= ch_len[i];
			end
		end
		if (state == S_WAIT)
			data_q <= b_rdata;
		if (state == S_WRITE) begin
			src_ptr[sel] <= src_ptr[sel] + 1'b1;
			dst_ptr[sel] <= dst_ptr[sel] + 1'b1;
			remain[sel]  <= remain[sel] - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/dma_regs.sv ====
// DMA register block decoding AXI4-Lite accesses to channel setup, status and memory
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dma_regs
	import dma_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [`ADDR_W-1:0] awaddr,
	input  logic              awvalid,
	output logic              awready,
	input  data_t             wdata,
	input  logic              wvalid,
	output logic              wready,
	output logic [1:0]        bresp,
	output logic              bvalid,
	input  logic              bready,
	input  logic [`ADDR_W-1:0] araddr,
	input  logic              arvalid,
	output logic              arready,
	output data_t             rdata,
	output logic [1:0]        rresp,
	output logic              rvalid,
	input  logic              rready,
	output ch_mask_t          start,
	output word_addr_t        ch_src [`NUM_CH],
	output word_addr_t        ch_dst [`NUM_CH],
	output word_addr_t        ch_len [`NUM_CH],
	output ch_mask_t          ch_level,
	input  ch_mask_t          done_set,
	input  ch_mask_t          busy,
	output word_addr_t        a_addr,
	output logic              a_we,
	output data_t             a_wdata,
	input  data_t             a_rdata
);

	localparam int STRIDE_SH = $clog2(`CH_STRIDE);

	logic       idle;
	logic       wr_go;
	logic       rd_go;
	logic       wr_hs;
	logic       rd_hs;
	logic       wr_is_ch;
	logic       wr_is_mem;
	logic       rd_is_ch;
	logic       rd_is_mem;
	ch_idx_t    wr_ch;
	ch_idx_t    rd_ch;
	ch_mask_t   w1c;
	ch_mask_t   done_q;
	data_t      reg_rdata;
	data_t      rd_reg_q;
	logic       rd_mem_q;
	word_addr_t rd_word_q;

	// one transaction at a time, write wins a tie
	assign idle  = !awready && !bvalid && !arready && !rvalid;
	assign wr_go = awvalid && wvalid && idle;
	assign rd_go = arvalid && idle && !wr_go;

	assign wr_hs = awvalid && awready && wvalid && wready;
	assign rd_hs = arvalid && arready;

	assign wr_is_mem = (awaddr >= `MEM_BASE) && (awaddr <= `MEM_END);
	assign rd_is_mem = (araddr >= `MEM_BASE) && (araddr <= `MEM_END);
	assign wr_is_ch  = awaddr < `ADDR_W'(`NUM_CH * `CH_STRIDE);
	assign rd_is_ch  = araddr < `ADDR_W'(`NUM_CH * `CH_STRIDE);
	assign wr_ch     = ch_idx_t'(awaddr >> STRIDE_SH);
	assign rd_ch     = ch_idx_t'(araddr >> STRIDE_SH);

	assign w1c = (wr_hs && awaddr == `REG_STATUS) ? wdata[`NUM_CH-1:0] : '0;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	// host memory port
	assign a_we    = wr_hs && wr_is_mem;
	assign a_wdata = wdata;
	always_comb begin
		if (awready)
			a_addr = word_addr_t'(awaddr >> 2);
		else if (arready)
			a_addr = word_addr_t'(araddr >> 2);
		else
			a_addr = rd_word_q; // hold so a_rdata stays put under rvalid
	end

	always_comb begin
		reg_rdata = '0;
		if (araddr == `REG_STATUS) begin
			reg_rdata = data_t'({busy, done_q});
		end else if (rd_is_ch) begin
			case (araddr[STRIDE_SH-1:0])
				`REG_CTRL: reg_rdata = data_t'({ch_level[rd_ch], busy[rd_ch]});
				`REG_SRC:  reg_rdata = data_t'(ch_src[rd_ch]);
				`REG_DST:  reg_rdata = data_t'(ch_dst[rd_ch]);
				`REG_LEN:  reg_rdata = data_t'(ch_len[rd_ch]);
				default:   reg_rdata = '0;
			endcase
		end
	end

	assign rdata = rd_mem_q ? a_rdata : rd_reg_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			awready  <= 1'b0;
			wready   <= 1'b0;
			arready  <= 1'b0;
			bvalid   <= 1'b0;
			rvalid   <= 1'b0;
			start    <= '0;
			ch_level <= '0;
			done_q   <= '0;
			rd_mem_q <= 1'b0;
		end else begin
			awready <= wr_go;
			wready  <= wr_go;
			arready <= rd_go;
			start   <= '0;

			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (rd_hs) begin
				rvalid   <= 1'b1;
				rd_mem_q <= rd_is_mem;
			end else if (rready) begin
				rvalid <= 1'b0;
			end

			if (wr_hs && wr_is_ch && awaddr[STRIDE_SH-1:0] == `REG_CTRL) begin
				ch_level[wr_ch] <= wdata[1];
				start[wr_ch]    <= wdata[0] && !busy[wr_ch]; // busy channel ignores
			end

			// a restart clears the old done, a new done beats a clear
			done_q <= (done_q & ~w1c & ~start) | done_set;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs && wr_is_ch) begin
			case (awaddr[STRIDE_SH-1:0])
				`REG_SRC: ch_src[wr_ch] <= word_addr_t'(wdata);
				`REG_DST: ch_dst[wr_ch] <= word_addr_t'(wdata);
				`REG_LEN: ch_len[wr_ch] <= word_addr_t'(wdata);
				default: ;
			endcase
		end
		if (rd_hs) begin
			rd_reg_q  <= reg_rdata;
			rd_word_q <= word_addr_t'(araddr >> 2);
		end
	end

endmodule

`default_nettype wire

// ==== design/dma_mem.sv ====
// DMA scratch memory, true dual port with registered reads
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dma_mem
	import dma_pkg::*;
(
	input  logic       clk,
	input  word_addr_t a_addr,
	input  logic       a_we,
	input  data_t      a_wdata,
	output data_t      a_rdata,
	input  word_addr_t b_addr,
	input  logic       b_we,
	input  data_t      b_wdata,
	output data_t      b_rdata
);

	data_t mem [`MEM_DEPTH];

	// host port
	always @(posedge clk) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_rdata <= mem[a_addr];
	end

	// engine port
	always @(posedge clk) begin
		if (b_we)
			mem[b_addr] <= b_wdata;
		b_rdata <= mem[b_addr];
	end

endmodule

`default_nettype wire

// ==== design/dma_arbiter.sv ====
// DMA channel arbiter picking the next channel by level, then round robin
`timescale 1ns/100ps
`default_nettype none

`include "dma_params.svh"

module dma_arbiter
	import dma_pkg::*;
(
	input  ch_mask_t request,
	input  ch_mask_t level,
	input  ch_idx_t  current_channel,
	output ch_idx_t  granted_channel
);

	ch_mask_t req_high;
	ch_mask_t req_low;
	ch_idx_t  pick_high;
	ch_idx_t  pick_low;

	// circular search starting after cur, cur itself checked last
	function automatic ch_idx_t rr_pick(input ch_mask_t req, input ch_idx_t cur);
		ch_idx_t pick;
		ch_idx_t idx;
		pick = cur;
		// walk from the far end so the nearest hit wins
		for (int k = `NUM_CH; k >= 1; k--) begin
			idx = cur + ch_idx_t'(k); // wraps
			if (req[idx])
				pick = idx;
		end
		return pick;
	endfunction

	assign req_high = request & level;
	assign req_low  = request & ~level;

	always_comb begin
		pick_high = rr_pick(req_high, current_channel);
		pick_low  = rr_pick(req_low, current_channel);
	end

	// any high request shuts out the low group
	assign granted_channel = (|req_high) ? pick_high : pick_low;

endmodule

`default_nettype wire

// ==== common/dma_pkg.sv ====
// DMA shared types for channel numbers, masks, word addresses and data
`default_nettype none

`include "dma_params.svh"

package dma_pkg;

	// channel number
	typedef logic [$clog2(`NUM_CH)-1:0] ch_idx_t;

	// one bit per channel
	typedef logic [`NUM_CH-1:0] ch_mask_t;

	// scratch memory word address, also the LEN register
	typedef logic [$clog2(`MEM_DEPTH)-1:0] word_addr_t;

	typedef logic [`DATA_W-1:0] data_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== common/dma_params.svh ====
// DMA subsystem sizes, AXI address map and channel register offsets
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

`define NUM_CH      8
`define MEM_DEPTH   256
`define DATA_W      32
`define ADDR_W      12

// channel register block, one per channel
`define CH_STRIDE   16
`define REG_CTRL    4'h0
`define REG_SRC     4'h4
`define REG_DST     4'h8
`define REG_LEN     4'hc

// done in [7:0], busy in [15:8]
`define REG_STATUS  12'h080

// host window onto the scratch memory
`define MEM_BASE    12'h400
`define MEM_END     12'h7ff

`endif
